// ==== verilog/bridge_pkg.sv ====
package bridge_pkg;

    // Word layout: 2-bit code above 32 data bits
    localparam int CMD_W  = 34;
    localparam int DATA_W = 32;
    localparam int ADDR_W = 30;

    // Command opcodes
    localparam logic [1:0] OP_SETADDR = 2'd0;
    localparam logic [1:0] OP_WRITE   = 2'd1;
    localparam logic [1:0] OP_READ    = 2'd2;

    // Response codes
    localparam logic [1:0] RSP_ACK  = 2'd1;
    localparam logic [1:0] RSP_DATA = 2'd2;
    localparam logic [1:0] RSP_ERR  = 2'd3;

    // 12 MHz / 115200 baud
    localparam int BAUD_DIV = 104;

    localparam int FRAME_BYTES = 5;
    localparam int REG_COUNT   = 16;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
    input  logic       i_clk_12Mhz,
    input  logic       i_rst,
    input  logic       i_rx,
    output logic [7:0] o_byte,
    output logic       o_byte_stb
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
    typedef logic [$clog2(BAUD_DIV)-1:0] baud_cnt_t;

    rx_state_t  state;
    logic [2:0] rx_sync;
    baud_cnt_t  baud_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift;

    assign o_byte = shift;

    // Bits 0..1 synchronize, bit 2 keeps the previous level for edge detection
    always_ff @(posedge i_clk_12Mhz) begin
        if (i_rst) begin
            rx_sync <= 3'b111;
        end else begin
            rx_sync <= {rx_sync[1:0], i_rx};
        end
    end

    always_ff @(posedge i_clk_12Mhz) begin
        if (i_rst) begin
            state      <= RX_IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            o_byte_stb <= 1'b0;
        end else begin
            o_byte_stb <= 1'b0;
            if (state != RX_IDLE && baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                case (state)
                    RX_IDLE: begin
                        if (rx_sync[2] && !rx_sync[1]) begin
                            state    <= RX_START;
                            baud_cnt <= baud_cnt_t'(BAUD_DIV / 2 - 1);
                        end
                    end
                    RX_START: begin
                        // Glitch filter: start bit must still be low mid-bit
                        state    <= rx_sync[1] ? RX_IDLE : RX_DATA;
                        baud_cnt <= baud_cnt_t'(BAUD_DIV - 1);
                        bit_idx  <= '0;
                    end
                    RX_DATA: begin
                        baud_cnt <= baud_cnt_t'(BAUD_DIV - 1);
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                    default: begin
                        o_byte_stb <= rx_sync[1];
                        state      <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge i_clk_12Mhz) begin
        if (state == RX_DATA && baud_cnt == '0) begin
            shift <= {rx_sync[1], shift[7:1]};
        end
    end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input  logic       i_clk_12Mhz,
    input  logic       i_rst,
    input  logic       i_start,
    input  logic [7:0] i_byte,
    output logic       o_tx,
    output logic       o_busy
);
    import bridge_pkg::*;

    typedef logic [$clog2(BAUD_DIV)-1:0] baud_cnt_t;

    baud_cnt_t  baud_cnt;
    logic [3:0] bit_cnt;
    logic [8:0] shift;

    always_ff @(posedge i_clk_12Mhz) begin
        if (i_rst) begin
            o_tx     <= 1'b1;
            o_busy   <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!o_busy) begin
            if (i_start) begin
                o_tx     <= 1'b0;
                o_busy   <= 1'b1;
                baud_cnt <= baud_cnt_t'(BAUD_DIV - 1);
                bit_cnt  <= '0;
            end
        end else if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
        end else if (bit_cnt == 4'd9) begin
            // End of stop bit
            o_busy <= 1'b0;
        end else begin
            o_tx     <= shift[0];
            bit_cnt  <= bit_cnt + 1'b1;
            baud_cnt <= baud_cnt_t'(BAUD_DIV - 1);
        end
    end

    // Data bits then the stop bit, shifted in from the top
    always_ff @(posedge i_clk_12Mhz) begin
        if (!o_busy && i_start) begin
            shift <= {1'b1, i_byte};
        end else if (o_busy && baud_cnt == '0) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

// ==== verilog/cmd_decoder.sv ====
`timescale 1ns/100ps

module cmd_decoder (
    input  logic                         i_clk_12Mhz,
    input  logic                         i_rst,
    input  logic [7:0]                   i_byte,
    input  logic                         i_byte_stb,
    input  logic                         i_busy,
    output logic [bridge_pkg::CMD_W-1:0] o_cmd_word,
    output logic                         o_cmd_stb
);
    import bridge_pkg::*;

    typedef logic [$clog2(FRAME_BYTES)-1:0] byte_cnt_t;

    logic [8*FRAME_BYTES-1:0] shift;
    byte_cnt_t                count;
    logic                     take;

    // Bytes arriving while the master is busy are lost
    assign take       = i_byte_stb && !i_busy;
    assign o_cmd_word = shift[CMD_W-1:0];

    always_ff @(posedge i_clk_12Mhz) begin
        if (i_rst) begin
            count     <= '0;
            o_cmd_stb <= 1'b0;
        end else begin
            o_cmd_stb <= 1'b0;
            if (take) begin
                if (count == byte_cnt_t'(FRAME_BYTES - 1)) begin
                    count     <= '0;
                    o_cmd_stb <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // First byte ends up on top, so its low two bits land on the opcode
    always_ff @(posedge i_clk_12Mhz) begin
        if (take) begin
            shift <= {shift[8*FRAME_BYTES-9:0], i_byte};
        end
    end

endmodule

// ==== verilog/wb_master.sv ====
`timescale 1ns/100ps

module wb_master (
    input  logic                          i_clk_12Mhz,
    input  logic                          i_rst,
    input  logic                          i_cmd_stb,
    input  logic [bridge_pkg::CMD_W-1:0]  i_cmd_word,
    output logic                          o_cmd_busy,
    output logic                          o_wb_cyc,
    output logic                          o_wb_stb,
    output logic                          o_wb_we,
    output logic [bridge_pkg::ADDR_W-1:0] o_wb_addr,
    output logic [bridge_pkg::DATA_W-1:0] o_wb_data,
    input  logic                          i_wb_ack,
    input  logic                          i_wb_err,
    input  logic [bridge_pkg::DATA_W-1:0] i_wb_data,
    output logic                          o_rsp_stb,
    output logic [bridge_pkg::CMD_W-1:0]  o_rsp_word,
    input  logic                          i_rsp_busy
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {M_IDLE, M_BUS, M_RSP} m_state_t;

    m_state_t          state;
    logic [ADDR_W-1:0] addr_q;
    logic [1:0]        opcode;
    logic              bus_cmd;
    logic              rsp_load;
    logic [CMD_W-1:0]  rsp_next;

    assign opcode     = i_cmd_word[CMD_W-1:DATA_W];
    assign bus_cmd    = opcode == OP_WRITE || opcode == OP_READ;
    assign o_wb_addr  = addr_q;
    assign o_cmd_busy = state != M_IDLE || o_rsp_stb;

    // Response source: immediate for set-address and bad opcodes, else bus result
    always_comb begin
        rsp_load = 1'b0;
        rsp_next = {RSP_ERR, {DATA_W{1'b0}}};
        if (state == M_IDLE && i_cmd_stb && !bus_cmd) begin
            rsp_load = 1'b1;
            if (opcode == OP_SETADDR) begin
                rsp_next = {RSP_ACK, {DATA_W{1'b0}}};
            end
        end else if (state == M_BUS && (i_wb_ack || i_wb_err)) begin
            rsp_load = 1'b1;
            if (i_wb_ack) begin
                rsp_next = o_wb_we ? {RSP_ACK, {DATA_W{1'b0}}} : {RSP_DATA, i_wb_data};
            end
        end
    end

    always_ff @(posedge i_clk_12Mhz) begin
        if (i_rst) begin
            state      <= M_IDLE;
            addr_q     <= '0;
            o_wb_cyc   <= 1'b0;
            o_wb_stb   <= 1'b0;
            o_wb_we    <= 1'b0;
            o_wb_data  <= '0;
            o_rsp_stb  <= 1'b0;
            o_rsp_word <= '0;
        end else begin
            o_wb_stb  <= 1'b0;
            o_rsp_stb <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (i_cmd_stb && opcode == OP_SETADDR) begin
                        addr_q <= i_cmd_word[ADDR_W-1:0];
                    end else if (i_cmd_stb && bus_cmd) begin
                        state     <= M_BUS;
                        o_wb_cyc  <= 1'b1;
                        o_wb_stb  <= 1'b1;
                        o_wb_we   <= opcode == OP_WRITE;
                        o_wb_data <= i_cmd_word[DATA_W-1:0];
                    end
                end
                M_BUS: begin
                    if (i_wb_ack || i_wb_err) begin
                        o_wb_cyc <= 1'b0;
                    end
                    // Errors keep the address where it was
                    if (i_wb_ack) begin
                        addr_q <= addr_q + 1'b1;
                    end
                end
                M_RSP: begin
                    if (!i_rsp_busy) begin
                        o_rsp_stb <= 1'b1;
                        state     <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
            if (rsp_load) begin
                o_rsp_word <= rsp_next;
                if (i_rsp_busy) begin
                    state <= M_RSP;
                end else begin
                    o_rsp_stb <= 1'b1;
                    state     <= M_IDLE;
                end
            end
        end
    end

endmodule

// ==== verilog/wb_regfile.sv ====
`timescale 1ns/100ps

module wb_regfile (
    input  logic                          i_clk_12Mhz,
    input  logic                          i_rst,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  logic [bridge_pkg::ADDR_W-1:0] i_wb_addr,
    input  logic [bridge_pkg::DATA_W-1:0] i_wb_data,
    output logic                          o_wb_ack,
    output logic                          o_wb_err,
    output logic [bridge_pkg::DATA_W-1:0] o_wb_data,
    output logic [7:0]                    o_leds
);
    import bridge_pkg::*;

    logic [DATA_W-1:0]            regs [REG_COUNT];
    logic [$clog2(REG_COUNT)-1:0] idx;
    logic                         access;
    logic                         in_range;

    assign access   = i_wb_cyc && i_wb_stb;
    assign in_range = i_wb_addr < ADDR_W'(REG_COUNT);
    assign idx      = i_wb_addr[$clog2(REG_COUNT)-1:0];
    assign o_leds   = regs[0][7:0];

    always_ff @(posedge i_clk_12Mhz) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            o_wb_ack <= access && in_range;
            o_wb_err <= access && !in_range;
            if (access && in_range && i_wb_we) begin
                regs[idx] <= i_wb_data;
            end
        end
    end

    // Out-of-range reads return zero
    always_ff @(posedge i_clk_12Mhz) begin
        if (access) begin
            o_wb_data <= (in_range && !i_wb_we) ? regs[idx] : '0;
        end
    end

endmodule

// ==== verilog/rsp_encoder.sv ====
`timescale 1ns/100ps

module rsp_encoder (
    input  logic                         i_clk_12Mhz,
    input  logic                         i_rst,
    input  logic                         i_rsp_stb,
    input  logic [bridge_pkg::CMD_W-1:0] i_rsp_word,
    output logic                         o_busy,
    output logic [7:0]                   o_tx_byte,
    output logic                         o_tx_start,
    input  logic                         i_tx_busy
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {E_IDLE, E_SEND, E_DRAIN} e_state_t;
    typedef logic [$clog2(FRAME_BYTES+1)-1:0] left_cnt_t;

    e_state_t                 state;
    left_cnt_t                left;
    logic [8*FRAME_BYTES-1:0] shift;
    logic                     tx_ready;

    // The transmitter raises busy one cycle after a start, so skip that cycle
    assign tx_ready  = !o_tx_start && !i_tx_busy;
    assign o_busy    = state != E_IDLE;
    assign o_tx_byte = shift[8*FRAME_BYTES-1 -: 8];

    always_ff @(posedge i_clk_12Mhz) begin
        if (i_rst) begin
            state      <= E_IDLE;
            left       <= '0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                E_IDLE: begin
                    if (i_rsp_stb) begin
                        state <= E_SEND;
                        left  <= left_cnt_t'(FRAME_BYTES);
                    end
                end
                E_SEND: begin
                    if (tx_ready) begin
                        o_tx_start <= 1'b1;
                        left       <= left - 1'b1;
                        if (left == left_cnt_t'(1)) begin
                            state <= E_DRAIN;
                        end
                    end
                end
                E_DRAIN: begin
                    if (tx_ready) begin
                        state <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    // Code byte on top, then data MSB first
    always_ff @(posedge i_clk_12Mhz) begin
        if (state == E_IDLE && i_rsp_stb) begin
            shift <= {{(8*FRAME_BYTES-CMD_W){1'b0}}, i_rsp_word};
        end else if (o_tx_start) begin
            shift <= {shift[8*FRAME_BYTES-9:0], 8'h00};
        end
    end

endmodule

// ==== verilog/uart_wb_bridge.sv ====
`timescale 1ns/100ps

module uart_wb_bridge (
    input  logic       i_clk_12Mhz,
    input  logic       i_rst,
    input  logic       i_uart_rx,
    output logic       o_uart_tx,
    output logic [7:0] o_leds
);
    import bridge_pkg::*;

    logic [7:0]        rx_byte;
    logic              rx_byte_stb;
    logic [CMD_W-1:0]  cmd_word;
    logic              cmd_stb;
    logic              cmd_busy;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0] wb_wdata;
    logic [DATA_W-1:0] wb_rdata;
    logic              wb_ack;
    logic              wb_err;
    logic [CMD_W-1:0]  rsp_word;
    logic              rsp_stb;
    logic              rsp_busy;
    logic [7:0]        tx_byte;
    logic              tx_start;
    logic              tx_busy;

    uart_rx u_uart_rx (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst       (i_rst),
        .i_rx        (i_uart_rx),
        .o_byte      (rx_byte),
        .o_byte_stb  (rx_byte_stb)
    );

    cmd_decoder u_cmd_decoder (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst       (i_rst),
        .i_byte      (rx_byte),
        .i_byte_stb  (rx_byte_stb),
        .i_busy      (cmd_busy),
        .o_cmd_word  (cmd_word),
        .o_cmd_stb   (cmd_stb)
    );

    wb_master u_wb_master (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst       (i_rst),
        .i_cmd_stb   (cmd_stb),
        .i_cmd_word  (cmd_word),
        .o_cmd_busy  (cmd_busy),
        .o_wb_cyc    (wb_cyc),
        .o_wb_stb    (wb_stb),
        .o_wb_we     (wb_we),
        .o_wb_addr   (wb_addr),
        .o_wb_data   (wb_wdata),
        .i_wb_ack    (wb_ack),
        .i_wb_err    (wb_err),
        .i_wb_data   (wb_rdata),
        .o_rsp_stb   (rsp_stb),
        .o_rsp_word  (rsp_word),
        .i_rsp_busy  (rsp_busy)
    );

    wb_regfile u_wb_regfile (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst       (i_rst),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_addr   (wb_addr),
        .i_wb_data   (wb_wdata),
        .o_wb_ack    (wb_ack),
        .o_wb_err    (wb_err),
        .o_wb_data   (wb_rdata),
        .o_leds      (o_leds)
    );

    rsp_encoder u_rsp_encoder (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst       (i_rst),
        .i_rsp_stb   (rsp_stb),
        .i_rsp_word  (rsp_word),
        .o_busy      (rsp_busy),
        .o_tx_byte   (tx_byte),
        .o_tx_start  (tx_start),
        .i_tx_busy   (tx_busy)
    );

    uart_tx u_uart_tx (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst       (i_rst),
        .i_start     (tx_start),
        .i_byte      (tx_byte),
        .o_tx        (o_uart_tx),
        .o_busy      (tx_busy)
    );

endmodule

// ==== tb/uart_wb_bridge_sva.sv ====
`timescale 1ns/100ps

module uart_wb_bridge_sva (
    input logic i_clk_12Mhz,
    input logic i_rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack,
    input logic i_wb_err,
    input logic i_rsp_stb,
    input logic i_rsp_busy
);
    int fail_cnt = 0;

    a_stb_in_cyc: assert property (@(posedge i_clk_12Mhz) disable iff (i_rst)
        i_wb_stb |-> i_wb_cyc)
        else begin
            fail_cnt++;
            $error("Wishbone stb asserted outside a bus cycle");
        end

    // Slave answers every request the next cycle, never both ways
    a_one_reply: assert property (@(posedge i_clk_12Mhz) disable iff (i_rst)
        i_wb_stb |=> (i_wb_ack ^ i_wb_err))
        else begin
            fail_cnt++;
            $error("Wishbone stb not followed by exactly one of ack or err");
        end

    a_rsp_when_free: assert property (@(posedge i_clk_12Mhz) disable iff (i_rst)
        !(i_rsp_stb && i_rsp_busy))
        else begin
            fail_cnt++;
            $error("Response strobe issued while the encoder was busy");
        end

endmodule

bind wb_master uart_wb_bridge_sva u_sva (
    .i_clk_12Mhz (i_clk_12Mhz),
    .i_rst       (i_rst),
    .i_wb_cyc    (o_wb_cyc),
    .i_wb_stb    (o_wb_stb),
    .i_wb_ack    (i_wb_ack),
    .i_wb_err    (i_wb_err),
    .i_rsp_stb   (o_rsp_stb),
    .i_rsp_busy  (i_rsp_busy)
);

// ==== tb/tb_uart_wb_bridge.sv ====
`timescale 1ns/100ps

module tb_uart_wb_bridge;
    import bridge_pkg::*;

    // One frame in and one frame out per command, with room for 30 commands
    localparam int MAX_CMDS       = 30;
    localparam int TIMEOUT_CYCLES = MAX_CMDS * FRAME_BYTES * 10 * BAUD_DIV * 2;

    logic        clk;
    logic        rst;
    logic        uart_rx;
    logic        uart_tx;
    logic [7:0]  leds;

    int          cycle_count = 0;
    int          errors      = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          fails_seen  = 0;
    integer      seed        = 43097;
    logic [31:0] wdata [3];
    logic [31:0] reg0_val;
    logic [31:0] junk;
    logic [7:0]  leds_before;

    uart_wb_bridge dut (
        .i_clk_12Mhz (clk),
        .i_rst       (rst),
        .i_uart_rx   (uart_rx),
        .o_uart_tx   (uart_tx),
        .o_leds      (leds)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout reached after %0d cycles, the bridge stopped answering", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Start bit, eight data bits LSB first, stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            uart_rx = bits[k];
            repeat (BAUD_DIV) @(negedge clk);
        end
    endtask

    task automatic send_frame(input logic [1:0] op, input logic [31:0] data);
        logic [39:0] frame;
        frame = {6'b0, op, data};
        for (int i = FRAME_BYTES - 1; i >= 0; i--) begin
            send_byte(frame[8*i +: 8]);
        end
    endtask

    task automatic recv_byte(output logic [7:0] b);
        while (uart_tx !== 1'b0) begin
            @(negedge clk);
        end
        repeat (BAUD_DIV / 2) @(negedge clk);
        assert (uart_tx === 1'b0) else begin
            errors++;
            $display("Response start bit did not stay low, time %0d ns", $time);
        end
        for (int k = 0; k < 8; k++) begin
            repeat (BAUD_DIV) @(negedge clk);
            b[k] = uart_tx;
        end
        repeat (BAUD_DIV) @(negedge clk);
        assert (uart_tx === 1'b1) else begin
            errors++;
            $display("Response stop bit missing, time %0d ns", $time);
        end
    endtask

    task automatic recv_frame(output logic [39:0] frame);
        logic [7:0] b;
        for (int i = FRAME_BYTES - 1; i >= 0; i--) begin
            recv_byte(b);
            frame[8*i +: 8] = b;
        end
    endtask

    task automatic check_rsp(input logic [1:0] op, input logic [31:0] data,
                             input logic [39:0] got,
                             input logic [1:0] exp_code, input logic [31:0] exp_data);
        logic [39:0] exp;
        exp = {6'b0, exp_code, exp_data};
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0d ns: op %0d data %h gave response %h, expected %h",
                     $time, op, data, got, exp);
        end
    endtask

    // Response may start while the command stop bit is still on the line
    task automatic run_cmd(input logic [1:0] op, input logic [31:0] data,
                           input logic [1:0] exp_code, input logic [31:0] exp_data);
        logic [39:0] got;
        fork
            send_frame(op, data);
            recv_frame(got);
        join
        check_rsp(op, data, got, exp_code, exp_data);
    endtask

    // Second frame arrives while the first response is still going out,
    // so its response has to wait for the encoder. Both must answer ACK
    task automatic run_cmd_pair(input logic [1:0] op_a, input logic [31:0] data_a,
                                input logic [1:0] op_b, input logic [31:0] data_b);
        logic [39:0] got_a;
        logic [39:0] got_b;
        fork
            begin
                send_frame(op_a, data_a);
                send_frame(op_b, data_b);
            end
            begin
                recv_frame(got_a);
                recv_frame(got_b);
            end
        join
        check_rsp(op_a, data_a, got_a, RSP_ACK, 32'd0);
        check_rsp(op_b, data_b, got_b, RSP_ACK, 32'd0);
    endtask

    task automatic finish_test(input string name);
        int total;
        total = errors + dut.u_wb_master.u_sva.fail_cnt;
        if (total == fails_seen) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s with %0d errors", name, total - fails_seen);
        end
        fails_seen = total;
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        uart_rx = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        assert (uart_tx === 1'b1 && leds === 8'h00) else begin
            errors++;
            $display("[ERROR] %0d ns: idle tx %b leds %h, expected 1 and 00", $time, uart_tx, leds);
        end
        finish_test("reset state");

        wdata[0] = $random(seed);
        run_cmd_pair(OP_SETADDR, 32'd5, OP_WRITE, wdata[0]);
        run_cmd(OP_SETADDR, 32'd5, RSP_ACK, 32'd0);
        run_cmd(OP_READ, 32'd0, RSP_DATA, wdata[0]);
        finish_test("write and read back");

        run_cmd(OP_SETADDR, 32'd2, RSP_ACK, 32'd0);
        for (int i = 0; i < 3; i++) begin
            wdata[i] = $random(seed);
            run_cmd(OP_WRITE, wdata[i], RSP_ACK, 32'd0);
        end
        run_cmd(OP_SETADDR, 32'd2, RSP_ACK, 32'd0);
        for (int i = 0; i < 3; i++) begin
            run_cmd(OP_READ, 32'd0, RSP_DATA, wdata[i]);
        end
        finish_test("auto-increment");

        reg0_val = $random(seed);
        // Nonzero low byte so the LEDs have to leave their reset value
        reg0_val[0] = 1'b1;
        run_cmd(OP_SETADDR, 32'd0, RSP_ACK, 32'd0);
        run_cmd(OP_WRITE, reg0_val, RSP_ACK, 32'd0);
        assert (leds === reg0_val[7:0]) else begin
            errors++;
            $display("[ERROR] %0d ns: leds %h, expected %h", $time, leds, reg0_val[7:0]);
        end
        finish_test("LED output");

        // Error keeps the address at 20 for the read
        leds_before = leds;
        junk = $random(seed);
        run_cmd(OP_SETADDR, 32'd20, RSP_ACK, 32'd0);
        run_cmd(OP_WRITE, junk, RSP_ERR, 32'd0);
        run_cmd(OP_READ, 32'd0, RSP_ERR, 32'd0);
        assert (leds === leds_before) else begin
            errors++;
            $display("[ERROR] %0d ns: leds %h, expected %h", $time, leds, leds_before);
        end
        run_cmd(OP_SETADDR, 32'd0, RSP_ACK, 32'd0);
        run_cmd(OP_READ, 32'd0, RSP_DATA, reg0_val);
        finish_test("out-of-range access");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== uart_wb_bridge.f ====
verilog/bridge_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_decoder.sv
verilog/wb_master.sv
verilog/wb_regfile.sv
verilog/rsp_encoder.sv
verilog/uart_wb_bridge.sv
tb/uart_wb_bridge_sva.sv
tb/tb_uart_wb_bridge.sv

// ==== Bender.yml ====
package:
  name: uart_wb_bridge

sources:
  - verilog/bridge_pkg.sv
  - verilog/uart_rx.sv
  - verilog/uart_tx.sv
  - verilog/cmd_decoder.sv
  - verilog/wb_master.sv
  - verilog/wb_regfile.sv
  - verilog/rsp_encoder.sv
  - verilog/uart_wb_bridge.sv
  - target: test
    files:
      - tb/uart_wb_bridge_sva.sv
      - tb/tb_uart_wb_bridge.sv
